/* cube_draw_pkg.sv */
// ------------------------------
// shared types, palette and the
// cube edge table
// ------------------------------
package cube_draw_pkg;

    localparam int CORDW    = 10;  // signed coordinate width
    localparam int LINE_CNT = 9;   // cube edges

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [3:0] cidx_t;  // palette index, 0 is background

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
    } line_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        rgb_t rgb;
    } video_t;

    typedef enum logic [2:0] {IDLE, ARM, INIT, DRAW, DONE} draw_state_e;
    typedef enum logic [1:0] {L_IDLE, INIT0, INIT1, PLOT} line_state_e;  // drawer

    // 16 colours as 12'hRGB
    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h223, 12'h528, 12'h086, 12'hA53, 12'h554, 12'hCCC, 12'hFFE,
        12'hF05, 12'hFA0, 12'hFE2, 12'h0E3, 12'h2AF, 12'h879, 12'hF7A, 12'hFCA
    };

    // cube in 32x24 space, front face then the receding edges
    localparam line_t CUBE_EDGES [LINE_CNT] = '{
        '{10'sd13, 10'sd9,  10'sd23, 10'sd9},
        '{10'sd23, 10'sd9,  10'sd23, 10'sd19},
        '{10'sd23, 10'sd19, 10'sd13, 10'sd19},
        '{10'sd13, 10'sd19, 10'sd13, 10'sd9},
        '{10'sd13, 10'sd19, 10'sd9,  10'sd15},
        '{10'sd9,  10'sd15, 10'sd9,  10'sd5},
        '{10'sd9,  10'sd5,  10'sd13, 10'sd9},
        '{10'sd9,  10'sd5,  10'sd19, 10'sd5},
        '{10'sd19, 10'sd5,  10'sd23, 10'sd9}
    };

endpackage

/* display_timings.sv */
// ------------------------------
// display timing: scan counters,
// sync, de, frame and line pulses
// ------------------------------
`timescale 1ns/1ns

module display_timings #(
    parameter int H_RES   = 64,
    parameter int V_RES   = 48,
    parameter int H_BLANK = 16,
    parameter int V_BLANK = 4
) (
    input  logic                  clk_100m,
    input  logic                  arst_n,
    output cube_draw_pkg::coord_t sx,
    output cube_draw_pkg::coord_t sy,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de,
    output logic                  frame,
    output logic                  line
);
    import cube_draw_pkg::*;

    localparam coord_t H_LAST = coord_t'(H_RES + H_BLANK - 1);
    localparam coord_t V_LAST = coord_t'(V_RES + V_BLANK - 1);
    localparam coord_t H_ACT  = coord_t'(H_RES);
    localparam coord_t V_ACT  = coord_t'(V_RES);
    // sync pulses sit in the middle half of each blanking interval
    localparam coord_t HS_STA = coord_t'(H_RES + H_BLANK / 4);
    localparam coord_t HS_END = coord_t'(H_RES + (H_BLANK * 3) / 4);
    localparam coord_t VS_STA = coord_t'(V_RES + V_BLANK / 4);
    localparam coord_t VS_END = coord_t'(V_RES + (V_BLANK * 3) / 4);

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin  // end of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : coord_t'(sy + 1);
        end else begin
            sx <= coord_t'(sx + 1);
        end
    end

    always_comb begin
        hsync = (sx >= HS_STA) && (sx < HS_END);  // active high
        vsync = (sy >= VS_STA) && (sy < VS_END);
        de    = (sx < H_ACT) && (sy < V_ACT);
        frame = (sx == '0) && (sy == '0);
        line  = (sx == '0);
    end

endmodule

/* line_list.sv */
// ------------------------------
// edge sequencer: feeds the cube
// edges to the line drawer
// ------------------------------
`timescale 1ns/1ns

module line_list (
    input  logic                 clk_100m,
    input  logic                 arst_n,
    input  logic                 redraw,
    input  cube_draw_pkg::cidx_t ink,
    input  logic                 frame,
    input  logic                 done,
    output cube_draw_pkg::line_t seg,
    output cube_draw_pkg::cidx_t cidx,
    output logic                 draw_start,
    output logic                 busy,
    output logic                 all_done
);
    import cube_draw_pkg::*;

    localparam int IDXW = $clog2(LINE_CNT);
    localparam logic [IDXW-1:0] LAST_IDX = IDXW'(LINE_CNT - 1);

    draw_state_e     state;
    logic [IDXW-1:0] idx;  // current edge

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            case (state)
                IDLE, DONE: state <= redraw ? ARM : IDLE;  // DONE also takes a redraw
                ARM: if (frame) begin
                    idx   <= '0;
                    state <= INIT;
                end
                INIT: state <= DRAW;
                DRAW: if (done) begin
                    if (idx == LAST_IDX) begin
                        state <= DONE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= INIT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // edge is loaded on the way into INIT, so it is stable at start
    always_ff @(posedge clk_100m) begin
        if (!busy && redraw) begin
            cidx <= ink;
        end
        if (state == ARM && frame) begin
            seg <= CUBE_EDGES[0];
        end else if (state == DRAW && done && idx != LAST_IDX) begin
            seg <= CUBE_EDGES[idx + 1'b1];
        end
    end

    always_comb begin
        draw_start = (state == INIT);
        busy       = (state == ARM) || (state == INIT) || (state == DRAW);
        all_done   = (state == DONE);  // busy already low here
    end

endmodule

/* draw_line.sv */
// ------------------------------
// Bresenham line drawer, all
// octants, stalled by oe
// ------------------------------
`timescale 1ns/1ns

module draw_line (
    input  logic                  clk_100m,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  oe,
    input  cube_draw_pkg::line_t  seg,
    output cube_draw_pkg::coord_t x,
    output cube_draw_pkg::coord_t y,
    output logic                  drawing,
    output logic                  done
);
    import cube_draw_pkg::*;

    typedef logic signed [CORDW+1:0] err_t;  // headroom for 2*err

    line_state_e state;
    logic        swap;
    logic        right;  // x steps up
    coord_t      xa, ya, xb, yb;
    coord_t      x_end, y_end;
    err_t        dx, dy, err, err2;
    logic        movx, movy, last;

    always_comb begin
        // order endpoints so y only ever increases
        swap    = seg.y0 > seg.y1;
        xa      = swap ? seg.x1 : seg.x0;
        ya      = swap ? seg.y1 : seg.y0;
        xb      = swap ? seg.x0 : seg.x1;
        yb      = swap ? seg.y0 : seg.y1;
        err2    = err <<< 1;
        movx    = err2 >= dy;
        movy    = err2 <= dx;
        last    = (x == x_end) && (y == y_end);
        drawing = (state == PLOT) && oe;
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state <= L_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                L_IDLE: if (start) state <= INIT0;
                INIT0: state <= INIT1;
                INIT1: state <= PLOT;
                PLOT: if (oe && last) begin  // final pixel goes out this cycle
                    state <= L_IDLE;
                    done  <= 1'b1;
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        case (state)
            L_IDLE: right <= xa < xb;
            INIT0: begin
                dx <= right ? xb - xa : xa - xb;  // |dx|
                dy <= ya - yb;                    // -|dy|
            end
            INIT1: begin
                err   <= dx + dy;
                x     <= xa;
                y     <= ya;
                x_end <= xb;
                y_end <= yb;
            end
            PLOT: if (oe && !last) begin
                if (movx) begin
                    x <= right ? coord_t'(x + 1) : coord_t'(x - 1);
                end
                if (movy) begin
                    y <= coord_t'(y + 1);
                end
                err <= err + (movx ? dy : '0) + (movy ? dx : '0);
            end
            default: ;
        endcase
    end

endmodule

/* framebuffer.sv */
// ------------------------------
// indexed framebuffer with scaled
// scan read and palette lookup
// ------------------------------
`timescale 1ns/1ns

module framebuffer #(
    parameter int WIDTH  = 32,
    parameter int HEIGHT = 24,
    parameter int SCALE  = 2
) (
    input  logic                  clk_100m,
    input  logic                  we,
    input  cube_draw_pkg::coord_t x,
    input  cube_draw_pkg::coord_t y,
    input  cube_draw_pkg::cidx_t  cidx,
    input  cube_draw_pkg::coord_t sx,
    input  cube_draw_pkg::coord_t sy,
    input  logic                  de,
    input  logic                  line,
    output cube_draw_pkg::rgb_t   pix
);
    import cube_draw_pkg::*;

    localparam int DEPTH = WIDTH * HEIGHT;
    localparam int ADDRW = $clog2(DEPTH);
    localparam int SUBW  = (SCALE > 1) ? $clog2(SCALE) : 1;
    localparam coord_t X_LIM  = coord_t'(WIDTH);
    localparam coord_t Y_LIM  = coord_t'(HEIGHT);
    localparam coord_t SX_END = coord_t'(WIDTH * SCALE - 1);   // last visible column
    localparam coord_t SY_END = coord_t'(HEIGHT * SCALE - 1);
    localparam logic [SUBW-1:0] SUB_LAST = SUBW'(SCALE - 1);

    cidx_t            mem [DEPTH];
    logic [ADDRW-1:0] addr_w, addr_r;
    logic [ADDRW-1:0] col, row_base;  // read position in fb space
    logic [SUBW-1:0]  sub_x, sub_y;   // repeat counters for scaling
    logic             in_bounds;
    cidx_t            cidx_q;
    logic             de_q;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_comb begin
        in_bounds = !x[CORDW-1] && (x < X_LIM) && !y[CORDW-1] && (y < Y_LIM);
        addr_w    = ADDRW'(y * WIDTH + x);
        addr_r    = row_base + col;
    end

    always_ff @(posedge clk_100m) begin
        if (we && in_bounds) begin
            mem[addr_w] <= cidx;
        end
        cidx_q <= mem[addr_r];
        de_q   <= de;
    end

    // sub_y tracks sy mod SCALE from each line pulse; the row moves at line end
    always_ff @(posedge clk_100m) begin
        if (line) begin
            sub_y <= (sy == '0 || sub_y == SUB_LAST) ? '0 : sub_y + 1'b1;
        end
        if (sx == SX_END) begin
            col   <= '0;
            sub_x <= '0;
            if (sy >= SY_END) begin
                row_base <= '0;  // blank lines hold the first row
            end else if (sub_y == SUB_LAST) begin
                row_base <= row_base + ADDRW'(WIDTH);
            end
        end else if (de) begin
            if (sub_x == SUB_LAST) begin
                sub_x <= '0;
                col   <= col + 1'b1;
            end else begin
                sub_x <= sub_x + 1'b1;
            end
        end
    end

    assign pix = de_q ? PALETTE[cidx_q] : PALETTE[0];

endmodule

/* cube_draw_top.sv */
// ------------------------------
// cube renderer top level
// ------------------------------
`timescale 1ns/1ns

module cube_draw_top #(
    parameter int H_RES   = 64,
    parameter int V_RES   = 48,
    parameter int H_BLANK = 16,
    parameter int V_BLANK = 4,
    parameter int WIDTH   = 32,
    parameter int HEIGHT  = 24,
    parameter int SCALE   = 2
) (
    input  logic                  clk_100m,
    input  logic                  arst_n,
    input  logic                  redraw,
    input  cube_draw_pkg::cidx_t  ink,
    input  logic                  draw_en,
    output cube_draw_pkg::video_t video,
    output logic                  busy,
    output logic                  draw_done
);
    import cube_draw_pkg::*;

    coord_t sx, sy;
    logic   hsync, vsync, de, frame, line;
    line_t  seg;
    cidx_t  cidx;
    logic   draw_start, drawing, done;
    coord_t x, y;
    rgb_t   pix;
    logic   hsync_q, vsync_q, de_q;  // match the framebuffer read

    display_timings #(
        .H_RES(H_RES), .V_RES(V_RES), .H_BLANK(H_BLANK), .V_BLANK(V_BLANK)
    ) u_timings (
        .clk_100m, .arst_n, .sx, .sy, .hsync, .vsync, .de, .frame, .line
    );

    line_list u_list (
        .clk_100m, .arst_n, .redraw, .ink, .frame, .done,
        .seg, .cidx, .draw_start, .busy, .all_done(draw_done)
    );

    draw_line u_draw (
        .clk_100m, .arst_n, .start(draw_start), .oe(draw_en), .seg,
        .x, .y, .drawing, .done
    );

    framebuffer #(
        .WIDTH(WIDTH), .HEIGHT(HEIGHT), .SCALE(SCALE)
    ) u_fb (
        .clk_100m, .we(drawing), .x, .y, .cidx, .sx, .sy, .de, .line, .pix
    );

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            de_q    <= 1'b0;
        end else begin
            hsync_q <= hsync;
            vsync_q <= vsync;
            de_q    <= de;
        end
    end

    always_comb begin
        video.hsync = hsync_q;
        video.vsync = vsync_q;
        video.de    = de_q;
        video.rgb   = pix;
    end

endmodule

/* cube_draw_assert.sv */
// ------------------------------
// list/drawer handshake assertions
// bound into drawer and sequencer
// ------------------------------
`timescale 1ns/1ns

module cube_draw_assert (
    input logic clk_100m,
    input logic arst_n,
    input logic req,     // pulse coming in from the other block
    input logic req_ok,  // state in which req may arrive
    input logic active,
    input logic done
);
    int fails = 0;

    req_in_state: assert property (@(posedge clk_100m) disable iff (!arst_n)
        req |-> req_ok)
        else begin
            $error("incoming pulse arrived outside its permitted state");
            fails++;
        end

    done_not_active: assert property (@(posedge clk_100m) disable iff (!arst_n)
        !(active && done))
        else begin
            $error("done overlaps the active level");
            fails++;
        end

    done_one_cycle: assert property (@(posedge clk_100m) disable iff (!arst_n)
        done |=> !done)
        else begin
            $error("done is longer than one cycle");
            fails++;
        end

endmodule

// start from the sequencer only reaches an idle drawer
bind draw_line cube_draw_assert u_draw_assert (
    .clk_100m(clk_100m),
    .arst_n(arst_n),
    .req(start),
    .req_ok(state == cube_draw_pkg::L_IDLE),
    .active(drawing),
    .done(done)
);

// drawer done only while the sequencer waits for it, never with a start
bind line_list cube_draw_assert u_list_assert (
    .clk_100m(clk_100m),
    .arst_n(arst_n),
    .req(done),
    .req_ok(state == cube_draw_pkg::DRAW),
    .active(draw_start),
    .done(done)
);

/* cube_draw_checker.sv */
// ------------------------------
// scoreboard: model framebuffer,
// video timing and busy protocol
// ------------------------------
`timescale 1ns/1ns

module cube_draw_checker #(
    parameter int H_RES   = 64,
    parameter int V_RES   = 48,
    parameter int H_BLANK = 16,
    parameter int V_BLANK = 4,
    parameter int WIDTH   = 32,
    parameter int HEIGHT  = 24,
    parameter int SCALE   = 2
) (
    input  logic                  clk_100m,
    input  logic                  arst_n,
    input  logic                  redraw,
    input  cube_draw_pkg::cidx_t  ink,
    input  cube_draw_pkg::video_t video,
    input  logic                  busy,
    input  logic                  draw_done,
    output int                    frames_checked,
    output int                    pixel_errs,
    output int                    timing_errs,
    output int                    proto_errs
);
    import cube_draw_pkg::*;

    localparam int H_TOTAL   = H_RES + H_BLANK;
    localparam int FRAME_CYC = H_TOTAL * (V_RES + V_BLANK);

    cidx_t model [WIDTH * HEIGHT];
    cidx_t ink_q;                       // colour of the pending redraw
    logic  pending, armed, checking;
    logic  hs_q, vs_q, de_q, seen_hs, seen_vs;
    int    px, py, de_cnt, hs_cnt, frame_cyc, line_cyc;
    rgb_t  expect_rgb;

    initial begin
        frames_checked = 0;
        pixel_errs     = 0;
        timing_errs    = 0;
        proto_errs     = 0;
        for (int i = 0; i < WIDTH * HEIGHT; i++) begin
            model[i] = '0;
        end
    end

    // reference Bresenham, endpoints ordered so y increases
    task automatic plot_edge(input line_t e, input cidx_t c);
        int xa, ya, xb, yb, dx, dy, err, e2, step;
        bit fin;
        fin = 1'b0;
        xa  = (e.y0 > e.y1) ? e.x1 : e.x0;
        ya  = (e.y0 > e.y1) ? e.y1 : e.y0;
        xb  = (e.y0 > e.y1) ? e.x0 : e.x1;
        yb  = (e.y0 > e.y1) ? e.y0 : e.y1;
        dx   = (xb > xa) ? xb - xa : xa - xb;
        dy   = ya - yb;  // never positive
        step = (xb > xa) ? 1 : -1;
        err  = dx + dy;
        while (!fin) begin
            if (xa >= 0 && xa < WIDTH && ya >= 0 && ya < HEIGHT) begin
                model[ya * WIDTH + xa] = c;
            end
            if (xa == xb && ya == yb) begin
                fin = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err = err + dy;
                    xa  = xa + step;
                end
                if (e2 <= dx) begin
                    err = err + dx;
                    ya  = ya + 1;
                end
            end
        end
    endtask

    task automatic compare_count(input string name, input int got, input int want);
        if (got != want) begin
            timing_errs++;
            $display("mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    always @(posedge clk_100m) begin
        if (!arst_n) begin
            if (busy || draw_done || video.hsync || video.vsync || video.de) begin
                proto_errs++;
                $display("ERROR: busy, draw_done or a video sync/de bit is high in reset");
            end
            pending  = 1'b0;
            armed    = 1'b0;
            checking = 1'b0;
            hs_q     = 1'b0;
            vs_q     = 1'b0;
            de_q     = 1'b0;
            seen_hs  = 1'b0;
            seen_vs  = 1'b0;
        end else begin
            if (draw_done) begin
                if (!pending) begin
                    proto_errs++;
                    $display("ERROR: draw_done came without a pending redraw at %0t", $time);
                end
                if (busy) begin
                    proto_errs++;
                    $display("mismatch busy at draw_done: got %h expected %h", busy, 1'b0);
                end
                pending = 1'b0;
                for (int i = 0; i < LINE_CNT; i++) begin
                    plot_edge(CUBE_EDGES[i], ink_q);
                end
                armed = 1'b1;  // compare the next whole frame
            end else if (busy !== pending) begin
                proto_errs++;
                $display("mismatch busy: got %h expected %h at %0t", busy, pending, $time);
            end
            if (redraw && !pending) begin
                pending = 1'b1;
                ink_q   = ink;
            end

            if (video.vsync && !vs_q) begin  // frame boundary
                if (seen_vs) begin
                    compare_count("frame length", frame_cyc, FRAME_CYC);
                    compare_count("de cycles per frame", de_cnt, H_RES * V_RES);
                    compare_count("hsync pulses per frame", hs_cnt, V_RES + V_BLANK);
                end
                if (checking) begin
                    checking = 1'b0;
                    frames_checked++;
                end
                if (armed) begin
                    armed    = 1'b0;
                    checking = 1'b1;
                end
                seen_vs   = 1'b1;
                frame_cyc = 0;
                de_cnt    = 0;
                hs_cnt    = 0;
                px        = 0;
                py        = 0;
            end
            frame_cyc++;
            if (video.hsync && !hs_q) begin
                if (seen_hs) compare_count("hsync period", line_cyc, H_TOTAL);
                seen_hs  = 1'b1;
                line_cyc = 0;
                hs_cnt++;
            end
            line_cyc++;

            if (video.de) begin
                de_cnt++;
                if (checking && px < H_RES && py < V_RES) begin
                    expect_rgb = PALETTE[model[(py / SCALE) * WIDTH + px / SCALE]];
                    if (video.rgb !== expect_rgb) begin
                        pixel_errs++;
                        $display("mismatch video.rgb at (%0d,%0d): got %h expected %h",
                                 px, py, video.rgb, expect_rgb);
                    end
                end
                px++;
            end else begin
                if (checking && video.rgb !== PALETTE[0]) begin
                    pixel_errs++;
                    $display("mismatch video.rgb in blanking: got %h expected %h",
                             video.rgb, PALETTE[0]);
                end
                if (de_q) begin  // end of an active line
                    px = 0;
                    py++;
                end
            end
            hs_q = video.hsync;
            vs_q = video.vsync;
            de_q = video.de;
        end
    end

endmodule

/* tb_cube_draw.sv */
// ------------------------------
// testbench top: clock, reset,
// random redraw stimulus, watchdog
// ------------------------------
`timescale 1ns/1ns

module tb_cube_draw;
    import cube_draw_pkg::*;

    localparam int H_RES   = 64;
    localparam int V_RES   = 48;
    localparam int H_BLANK = 16;
    localparam int V_BLANK = 4;
    localparam int WIDTH   = 32;
    localparam int HEIGHT  = 24;
    localparam int SCALE   = 2;
    localparam int DRAWS   = 3;
    localparam int FRAME_CYC       = (H_RES + H_BLANK) * (V_RES + V_BLANK);
    localparam int FRAMES_PER_DRAW = 4;  // arm wait, drawing, lead-in, compared frame
    localparam int WATCHDOG_NS     = (FRAME_CYC * FRAMES_PER_DRAW * DRAWS + 2000) * 10;

    logic   clk_100m, arst_n, redraw, draw_en;
    cidx_t  ink, last_ink;
    video_t video;
    logic   busy, draw_done;
    int     frames_checked, pixel_errs, timing_errs, proto_errs, assert_errs;
    integer seed;
    int     run_len, gap;

    cube_draw_top #(
        .H_RES(H_RES), .V_RES(V_RES), .H_BLANK(H_BLANK), .V_BLANK(V_BLANK),
        .WIDTH(WIDTH), .HEIGHT(HEIGHT), .SCALE(SCALE)
    ) dut (
        .clk_100m, .arst_n, .redraw, .ink, .draw_en, .video, .busy, .draw_done
    );

    cube_draw_checker #(
        .H_RES(H_RES), .V_RES(V_RES), .H_BLANK(H_BLANK), .V_BLANK(V_BLANK),
        .WIDTH(WIDTH), .HEIGHT(HEIGHT), .SCALE(SCALE)
    ) u_checker (
        .clk_100m, .arst_n, .redraw, .ink, .video, .busy, .draw_done,
        .frames_checked, .pixel_errs, .timing_errs, .proto_errs
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the redraws did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    // waits for the falling edge, draw_en comes in random runs
    task automatic advance_cycle();
        @(negedge clk_100m);
        if (run_len == 0) begin
            draw_en = ($unsigned($random(seed)) % 10) < 7;  // about 70% high
            run_len = 1 + $unsigned($random(seed)) % 64;
        end
        run_len--;
    endtask

    initial begin
        seed     = 32'hac09_b4cc;
        arst_n   = 1'b0;
        redraw   = 1'b0;
        ink      = '0;
        last_ink = '0;
        draw_en  = 1'b0;
        run_len  = 0;
        repeat (4) @(posedge clk_100m);
        @(negedge clk_100m);
        arst_n = 1'b1;
        for (int n = 0; n < DRAWS; n++) begin
            gap = $unsigned($random(seed)) % 200;
            repeat (gap) advance_cycle();
            advance_cycle();
            ink = last_ink;
            while (ink == last_ink || ink == '0) begin  // new nonzero colour
                ink = cidx_t'($unsigned($random(seed)));
            end
            redraw = 1'b1;
            advance_cycle();
            redraw   = 1'b0;
            last_ink = ink;
            while (frames_checked < n + 1) advance_cycle();
        end
        assert_errs = dut.u_draw.u_draw_assert.fails + dut.u_list.u_list_assert.fails;
        $display("errors: pixel %0d, timing %0d, protocol %0d, assertion %0d",
                 pixel_errs, timing_errs, proto_errs, assert_errs);
        if (pixel_errs + timing_errs + proto_errs + assert_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* cube_draw.f */
cube_draw_pkg.sv
display_timings.sv
line_list.sv
draw_line.sv
framebuffer.sv
cube_draw_top.sv
cube_draw_assert.sv
cube_draw_checker.sv
tb_cube_draw.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cube renderer testbench with Verilator
rm -f sim.log && \
verilator --binary --timing --assert -Wno-fatal --top-module tb_cube_draw \
    -f cube_draw.f -o sim_cube_draw && \
./obj_dir/sim_cube_draw +verilator+error+limit+100 > sim.log 2>&1
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
